// ==== build.f ====
+incdir+design
design/masked_mult_pkg.sv
design/mask_rng.sv
design/masked_share_mult.sv
design/barrett_reduce.sv
design/masked_bfu_mult_reduce.sv
design/masked_mult_top.sv
tb/tb_clock_gen.sv
tb/tb_masked_mult.sv

// ==== design/barrett_reduce.sv ====
// Barrett reducer modulo q
// Reduces one 48-bit value below q in three pipeline stages that form
// a quotient estimate, a remainder and a final correction

`include "masked_mult_defines.svh"

module barrett_reduce (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     zeroize,
    input  masked_mult_pkg::wide_t   x,
    output masked_mult_pkg::share_t  y
);

    // Full width of x * mu
    localparam int PROD_W = `MM_WIDTH + `MM_BARRETT_MU_WIDTH;
    // Quotient estimate width after the shift by k
    localparam int QHAT_W = PROD_W - `MM_BARRETT_K;
    // Remainder before correction is below 3q, which needs two extra bits
    localparam int REM_W  = `MM_Q_WIDTH + 2;

    logic [PROD_W-1:0]       prod;
    logic [QHAT_W-1:0]       qhat;
    masked_mult_pkg::wide_t  x_s1;
    masked_mult_pkg::wide_t  diff;
    logic [REM_W-1:0]        rem;
    logic [REM_W-1:0]        sub1;
    logic [REM_W-1:0]        sub2;

    // ========================================
    // Quotient estimate in stage one
    // ========================================

    assign prod = PROD_W'(x) * PROD_W'(`MM_BARRETT_MU);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            qhat <= '0;
            x_s1 <= '0;
        end else if (zeroize) begin
            qhat <= '0;
            x_s1 <= '0;
        end else begin
            // floor(x * mu / 2^k) undershoots floor(x / q) by at most 2
            qhat <= prod[PROD_W-1:`MM_BARRETT_K];
            x_s1 <= x;
        end
    end

    // ========================================
    // Remainder in stage two
    // ========================================

    // qhat * q never exceeds x, so the subtraction does not wrap
    assign diff = x_s1 - masked_mult_pkg::wide_t'(qhat) * masked_mult_pkg::wide_t'(`MM_Q);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rem <= '0;
        end else if (zeroize) begin
            rem <= '0;
        end else begin
            // Only the low bits are live since the remainder is below 3q
            rem <= diff[REM_W-1:0];
        end
    end

    // ========================================
    // Final correction in stage three
    // ========================================

    // Two conditional subtractions bring [0, 3q) down to [0, q)
    always_comb begin
        if (rem >= REM_W'(`MM_Q)) begin
            sub1 = rem - REM_W'(`MM_Q);
        end else begin
            sub1 = rem;
        end
        if (sub1 >= REM_W'(`MM_Q)) begin
            sub2 = sub1 - REM_W'(`MM_Q);
        end else begin
            sub2 = sub1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            y <= '0;
        end else if (zeroize) begin
            y <= '0;
        end else begin
            y <= masked_mult_pkg::share_t'(sub2);
        end
    end

endmodule

// ==== design/mask_rng.sv ====
// Masking value generator
// Free-running 23-bit Fibonacci LFSR folded below q, one fresh mask per cycle

`include "masked_mult_defines.svh"

module mask_rng (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     zeroize,
    output masked_mult_pkg::share_t  rnd
);

    // Raw LFSR state that is never zero while running
    logic [`MM_Q_WIDTH-1:0] lfsr;
    logic                   feedback;
    // LFSR state brought into [0, q)
    masked_mult_pkg::share_t folded;

    // Taps 23 and 18 give a maximal-length sequence (x^23 + x^18 + 1)
    assign feedback = lfsr[22] ^ lfsr[17];

    // 2^23 - q is below q, so a single subtraction always lands below q
    always_comb begin
        if (lfsr >= `MM_Q_WIDTH'(`MM_Q)) begin
            folded = lfsr - `MM_Q_WIDTH'(`MM_Q);
        end else begin
            folded = lfsr;
        end
    end

    // ========================================
    // State and output register
    // ========================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lfsr <= `MM_LFSR_SEED;
            rnd  <= '0;
        end else if (zeroize) begin
            // Zeroize restarts the sequence from the seed
            lfsr <= `MM_LFSR_SEED;
            rnd  <= '0;
        end else begin
            lfsr <= {lfsr[21:0], feedback};
            // Registered so the consumer sees a stable mask for the whole cycle
            rnd  <= folded;
        end
    end

endmodule

// ==== design/masked_bfu_mult_reduce.sv ====
// Masked multiply and reduce stage of the NTT butterfly
// Masked share multiplication, independent Barrett reduction of each
// share, a registered output pair and a matching valid delay line
// Latency is six cycles from in_valid to out_valid

`include "masked_mult_defines.svh"

module masked_bfu_mult_reduce (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     zeroize,
    input  logic                     in_valid,
    input  masked_mult_pkg::share_t  u0,
    input  masked_mult_pkg::share_t  u1,
    input  masked_mult_pkg::share_t  v0,
    input  masked_mult_pkg::share_t  v1,
    input  masked_mult_pkg::share_t  rnd,
    output logic                     out_valid,
    output masked_mult_pkg::share_t  res0,
    output masked_mult_pkg::share_t  res1
);

    masked_mult_pkg::wide_t   z0;
    masked_mult_pkg::wide_t   z1;
    masked_mult_pkg::share_t  y0;
    masked_mult_pkg::share_t  y1;
    // One bit per pipeline stage with the oldest set at the top
    logic [`MM_PIPE_LATENCY-1:0] valid_sr;

    // Two-cycle share multiply with rnd used directly as the mask
    masked_share_mult u_share_mult (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .u0      (u0),
        .u1      (u1),
        .v0      (v0),
        .v1      (v1),
        .r       (rnd),
        .z0      (z0),
        .z1      (z1)
    );

    // Each share is reduced on its own so the secret is never recombined
    barrett_reduce u_reduce0 (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .x       (z0),
        .y       (y0)
    );

    barrett_reduce u_reduce1 (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .x       (z1),
        .y       (y1)
    );

    // ========================================
    // Output register and valid line
    // ========================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            res0     <= '0;
            res1     <= '0;
            valid_sr <= '0;
        end else if (zeroize) begin
            // Sets in flight are dropped along with their data
            res0     <= '0;
            res1     <= '0;
            valid_sr <= '0;
        end else begin
            res0     <= y0;
            res1     <= y1;
            valid_sr <= {valid_sr[`MM_PIPE_LATENCY-2:0], in_valid};
        end
    end

    assign out_valid = valid_sr[`MM_PIPE_LATENCY-1];

endmodule

// ==== design/masked_mult_defines.svh ====
// Masked ML-DSA multiplier constants
// Modulus, share and product widths, Barrett constants, pipeline depth
// and the LFSR seed shared by the RTL and the testbench

`ifndef MASKED_MULT_DEFINES_SVH
`define MASKED_MULT_DEFINES_SVH

// ML-DSA prime q = 2^23 - 2^13 + 1
`define MM_Q 32'd8380417

// One reduced share fits in 23 bits
`define MM_Q_WIDTH 23

// An unreduced product share of up to 2*(q-1)^2 + q stays below 2^48
`define MM_WIDTH 48

// Barrett shift and mu = floor(2^48 / q)
`define MM_BARRETT_K 48
`define MM_BARRETT_MU 26'd33587228
`define MM_BARRETT_MU_WIDTH 26

// Input strobe to output strobe takes 2 multiply, 3 reduce and 1 output register cycles
`define MM_PIPE_LATENCY 6

// Nonzero start state of the masking LFSR
`define MM_LFSR_SEED 23'h5a3c71

`endif

// ==== design/masked_mult_pkg.sv ====
// Masked multiplier type package
// Share and unreduced product types used on every datapath port

`include "masked_mult_defines.svh"

package masked_mult_pkg;

    // ========================================
    // Datapath types
    // ========================================

    // One arithmetic share kept below q on every module boundary
    typedef logic [`MM_Q_WIDTH-1:0] share_t;

    // One unreduced share out of the share multiplier
    // It holds two cross products plus the mask for at most 2*(q-1)^2 + q
    typedef logic [`MM_WIDTH-1:0] wide_t;

endpackage

// ==== design/masked_mult_top.sv ====
// Masked modular multiplier top level
// Connects the on-chip mask generator to the masked multiply-reduce stage
// Results come out as two shares below q that sum to u*v mod q

module masked_mult_top (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     zeroize,
    input  logic                     in_valid,
    input  masked_mult_pkg::share_t  u0,
    input  masked_mult_pkg::share_t  u1,
    input  masked_mult_pkg::share_t  v0,
    input  masked_mult_pkg::share_t  v1,
    output logic                     out_valid,
    output masked_mult_pkg::share_t  res0,
    output masked_mult_pkg::share_t  res1
);

    // Fresh mask below q, sampled with the operands
    masked_mult_pkg::share_t rnd;

    // ========================================
    // Mask source and datapath
    // ========================================

    mask_rng u_mask_rng (
        .clk     (clk),
        .reset_n (reset_n),
        .zeroize (zeroize),
        .rnd     (rnd)
    );

    masked_bfu_mult_reduce u_mult_reduce (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .in_valid  (in_valid),
        .u0        (u0),
        .u1        (u1),
        .v0        (v0),
        .v1        (v1),
        .rnd       (rnd),
        .out_valid (out_valid),
        .res0      (res0),
        .res1      (res1)
    );

endmodule

// ==== design/masked_share_mult.sv ====
// Two-share masked multiplier
// Multiplies operands (u0 + u1) and (v0 + v1) into two wide shares z0, z1
// whose sum is u*v + q, with a fresh mask r hiding each partial sum
// Latency is two cycles from inputs to z shares

`include "masked_mult_defines.svh"

module masked_share_mult (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     zeroize,
    input  masked_mult_pkg::share_t  u0,
    input  masked_mult_pkg::share_t  u1,
    input  masked_mult_pkg::share_t  v0,
    input  masked_mult_pkg::share_t  v1,
    input  masked_mult_pkg::share_t  r,
    output masked_mult_pkg::wide_t   z0,
    output masked_mult_pkg::wide_t   z1
);

    // Stage one cross products are each at most (q-1)^2
    masked_mult_pkg::wide_t p00;
    masked_mult_pkg::wide_t p01;
    masked_mult_pkg::wide_t p10;
    masked_mult_pkg::wide_t p11;
    // Mask and its complement carried next to the products
    masked_mult_pkg::share_t mask_pos;
    masked_mult_pkg::share_t mask_neg;
    masked_mult_pkg::share_t mask_neg_d;

    // q - r lies in [1, q], and q itself still fits in 23 bits
    assign mask_neg_d = masked_mult_pkg::share_t'(`MM_Q - 32'(r));

    // ========================================
    // Cross products in stage one
    // ========================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            p00      <= '0;
            p01      <= '0;
            p10      <= '0;
            p11      <= '0;
            mask_pos <= '0;
            mask_neg <= '0;
        end else if (zeroize) begin
            p00      <= '0;
            p01      <= '0;
            p10      <= '0;
            p11      <= '0;
            mask_pos <= '0;
            mask_neg <= '0;
        end else begin
            // Widen before multiplying so the 46-bit product is not truncated
            p00      <= masked_mult_pkg::wide_t'(u0) * masked_mult_pkg::wide_t'(v0);
            p01      <= masked_mult_pkg::wide_t'(u0) * masked_mult_pkg::wide_t'(v1);
            p10      <= masked_mult_pkg::wide_t'(u1) * masked_mult_pkg::wide_t'(v0);
            p11      <= masked_mult_pkg::wide_t'(u1) * masked_mult_pkg::wide_t'(v1);
            mask_pos <= r;
            mask_neg <= mask_neg_d;
        end
    end

    // ========================================
    // Masked share sums in stage two
    // ========================================

    // z0 only sees u0 and z1 only sees u1, each blinded by the mask
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            z0 <= '0;
            z1 <= '0;
        end else if (zeroize) begin
            z0 <= '0;
            z1 <= '0;
        end else begin
            z0 <= p00 + p01 + masked_mult_pkg::wide_t'(mask_pos);
            z1 <= p10 + p11 + masked_mult_pkg::wide_t'(mask_neg);
        end
    end

endmodule

// ==== tb/tb_clock_gen.sv ====
// Testbench clock and reset source
// Free-running clock and an active-low reset held for a fixed cycle count

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release lands just after an edge, like the rest of the stimulus
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset_n = 1'b1;
    end

endmodule

// ==== tb/tb_masked_mult.sv ====
// Testbench for the masked ML-DSA modular multiplier
// Drives random, back-to-back, edge and zeroize traffic into the DUT and
// checks the recombined result shares against a product model

`include "masked_mult_defines.svh"

module tb_masked_mult;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int LAT          = `MM_PIPE_LATENCY;
    localparam int RAND_SETS    = 200;
    localparam int MAX_GAP      = 3;
    localparam int BURST_SETS   = 100;
    localparam int EDGE_SETS    = 81;
    localparam int ZERO_CYCLES  = 20;
    // Every phase plus one drain per test
    localparam int TEST_CYCLES  = RESET_CYCLES + 2 + RAND_SETS * (1 + MAX_GAP) + BURST_SETS
                                  + EDGE_SETS + ZERO_CYCLES + 5 * (2 * LAT + 2);
    localparam int WATCHDOG_NS  = (TEST_CYCLES + LAT + 100) * CLK_PERIOD;

    logic                    clk;
    logic                    reset_n;
    logic                    zeroize;
    logic                    in_valid;
    masked_mult_pkg::share_t u0;
    masked_mult_pkg::share_t u1;
    masked_mult_pkg::share_t v0;
    masked_mult_pkg::share_t v1;
    logic                    out_valid;
    masked_mult_pkg::share_t res0;
    masked_mult_pkg::share_t res1;

    integer seed = 32'h744e;
    int     cyc = 0;
    // Expected product and the cycle its out_valid must show up in
    logic [63:0] exp_val_q[$];
    int          exp_cyc_q[$];

    string cur_test;
    int    test_errors = 0;
    int    total_errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;

    masked_mult_pkg::share_t edge_vals[3];

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    masked_mult_top u_masked_mult_top (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .in_valid  (in_valid),
        .u0        (u0),
        .u1        (u1),
        .v0        (v0),
        .v1        (v1),
        .out_valid (out_valid),
        .res0      (res0),
        .res1      (res1)
    );

    // ========================================
    // Model and reporting helpers
    // ========================================

    // Cycle count advances on each rising edge and is read later by drives and samples
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic masked_mult_pkg::share_t rand_share();
        logic [31:0] raw;
        raw = $random(seed);
        return masked_mult_pkg::share_t'(raw % `MM_Q);
    endfunction

    // Secret u is u0 + u1 and secret v is v0 + v1, both taken modulo q
    function automatic logic [63:0] model_product(input logic [63:0] a0, input logic [63:0] a1,
                                                  input logic [63:0] b0, input logic [63:0] b1);
        return ((a0 + a1) * (b0 + b1)) % 64'(`MM_Q);
    endfunction

    task automatic note_mismatch(input string what, input longint expv, input longint actv);
        $display("Mismatch in %s, %s: expected %0d, actual %0d", cur_test, what, expv, actv);
        test_errors++;
        total_errors++;
    endtask

    task automatic note_failure(input string msg);
        $display("Error in %s: %s", cur_test, msg);
        test_errors++;
        total_errors++;
    endtask

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("PASS %s", cur_test);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", cur_test, test_errors);
        end
    endtask

    // ========================================
    // Stimulus tasks
    // ========================================

    // Drives one strobed set where keep=0 marks a set that zeroize is expected to drop
    task automatic drive_set(input masked_mult_pkg::share_t a0, input masked_mult_pkg::share_t a1,
                             input masked_mult_pkg::share_t b0, input masked_mult_pkg::share_t b1,
                             input bit keep);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        u0       = a0;
        u1       = a1;
        v0       = b0;
        v1       = b1;
        if (keep) begin
            exp_val_q.push_back(model_product(a0, a1, b0, b1));
            exp_cyc_q.push_back(cyc + LAT);
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        zeroize  = 1'b0;
        u0       = '0;
        u1       = '0;
        v0       = '0;
        v1       = '0;
    endtask

    // Waits for every pending set, then watches a little longer for strays
    task automatic wait_drain();
        while (exp_val_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (LAT + 2) @(negedge clk);
    endtask

    // Called right after a falling edge, when the outputs are settled
    task automatic check_outputs_clear();
        if (out_valid !== 1'b0) begin
            note_failure("out_valid is set while the pipeline should be empty");
        end
        if (res0 !== '0) begin
            note_mismatch("res0", 0, res0);
        end
        if (res1 !== '0) begin
            note_mismatch("res1", 0, res1);
        end
    endtask

    // ========================================
    // Output monitor
    // ========================================

    always @(negedge clk) begin
        logic [63:0] sum;
        if (reset_n === 1'b1) begin
            if (out_valid === 1'b1) begin
                if (exp_val_q.size() == 0) begin
                    note_failure("out_valid rose with no set pending");
                end else begin
                    if (exp_cyc_q[0] != cyc) begin
                        note_mismatch("latency", LAT, LAT + cyc - exp_cyc_q[0]);
                    end
                    if (res0 >= `MM_Q) begin
                        note_failure($sformatf("res0 share %0d is not below q", res0));
                    end
                    if (res1 >= `MM_Q) begin
                        note_failure($sformatf("res1 share %0d is not below q", res1));
                    end
                    sum = (64'(res0) + 64'(res1)) % 64'(`MM_Q);
                    if (sum != exp_val_q[0]) begin
                        note_mismatch("product", exp_val_q[0], sum);
                    end
                    void'(exp_val_q.pop_front());
                    void'(exp_cyc_q.pop_front());
                end
            end else if (exp_cyc_q.size() != 0 && exp_cyc_q[0] <= cyc) begin
                note_failure("out_valid did not arrive for a pending set");
                void'(exp_val_q.pop_front());
                void'(exp_cyc_q.pop_front());
            end
        end
    end

    // ========================================
    // Test sequence
    // ========================================

    initial begin
        int gap;
        zeroize      = 1'b0;
        in_valid     = 1'b0;
        u0           = '0;
        u1           = '0;
        v0           = '0;
        v1           = '0;
        edge_vals[0] = '0;
        edge_vals[1] = masked_mult_pkg::share_t'(1);
        edge_vals[2] = masked_mult_pkg::share_t'(`MM_Q - 1);

        // Outputs must read zero during reset and just after it
        begin_test("reset_state");
        while (reset_n !== 1'b1) begin
            @(negedge clk);
            check_outputs_clear();
        end
        repeat (2) begin
            @(negedge clk);
            check_outputs_clear();
        end
        end_test();

        begin_test("random_products");
        for (int i = 0; i < RAND_SETS; i++) begin
            drive_set(rand_share(), rand_share(), rand_share(), rand_share(), 1'b1);
            gap = 1 + (($random(seed) & 32'h7fffffff) % MAX_GAP);
            repeat (gap) idle_cycle();
        end
        wait_drain();
        end_test();

        // Each set's latency check also proves out_valid stays high for the burst
        begin_test("back_to_back");
        for (int i = 0; i < BURST_SETS; i++) begin
            drive_set(rand_share(), rand_share(), rand_share(), rand_share(), 1'b1);
        end
        idle_cycle();
        wait_drain();
        end_test();

        // All 81 choices of 0, 1 and q-1 for the four shares
        begin_test("edge_operands");
        for (int a = 0; a < 3; a++) begin
            for (int b = 0; b < 3; b++) begin
                for (int c = 0; c < 3; c++) begin
                    for (int d = 0; d < 3; d++) begin
                        drive_set(edge_vals[a], edge_vals[b], edge_vals[c], edge_vals[d], 1'b1);
                    end
                end
            end
        end
        idle_cycle();
        wait_drain();
        end_test();

        begin_test("zeroize");
        // Three sets in flight, none of them may come out
        for (int i = 0; i < 3; i++) begin
            drive_set(rand_share(), rand_share(), rand_share(), rand_share(), 1'b0);
        end
        idle_cycle();
        // A set strobed during zeroize is lost as well
        drive_set(rand_share(), rand_share(), rand_share(), rand_share(), 1'b0);
        zeroize = 1'b1;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        @(negedge clk);
        check_outputs_clear();
        idle_cycle();
        @(negedge clk);
        check_outputs_clear();
        repeat (2) begin
            @(negedge clk);
            check_outputs_clear();
        end
        // Traffic after release runs with the normal latency
        for (int i = 0; i < 10; i++) begin
            drive_set(rand_share(), rand_share(), rand_share(), rand_share(), 1'b1);
        end
        idle_cycle();
        wait_drain();
        end_test();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Bounded by the summed test length, the pipeline depth and a margin
    initial begin
        #(WATCHDOG_NS);
        $display("The run timed out after %0d ns in test %s", WATCHDOG_NS, cur_test);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
